/* files.f */
+incdir+source
source/median_pkg.sv
source/sort3.sv
source/median_calc.sv
source/window_buffer.sv
source/pixel_counter.sv
source/frame_ctrl.sv
source/median_filter_top.sv
tests/median_filter_tb.sv

/* Bender.yml */
package:
  name: median_filter

sources:
  - include_dirs:
      - source
    files:
      - source/median_pkg.sv
      - source/sort3.sv
      - source/median_calc.sv
      - source/window_buffer.sv
      - source/pixel_counter.sv
      - source/frame_ctrl.sv
      - source/median_filter_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/median_filter_tb.sv

/* tests/median_filter_tb.sv */
`timescale 1ns/10ps

`include "median_macros.svh"

module median_filter_tb;

  localparam int OUT_PER_FRAME = (`IMG_W - 2) * (`IMG_H - 2);
  localparam int FRAME_PIX     = `IMG_W * `IMG_H;
  localparam int NUM_FRAMES    = 10;
  localparam int FULL_FRAMES   = 9;
  localparam int CYCLE_LIMIT   = NUM_FRAMES * `IMG_W * `IMG_H * 8 + 200;

  typedef enum {FILL_RANDOM, FILL_ZERO, FILL_FULL, FILL_CONST, FILL_CHECKER} fill_t;

  logic               clk;
  logic               rst_n;
  logic               in_req;
  median_pkg::pixel_t in_pix;
  logic               in_ack;
  median_pkg::pixel_t median;
  logic               median_valid;
  logic               frame_done;

  median_pkg::pixel_t frame_mem [`IMG_H][`IMG_W];
  median_pkg::pixel_t exp_q [$];

  int    mismatch_count = 0;
  int    error_count    = 0;
  int    out_count      = 0;
  int    done_count     = 0;
  int    cycle_count    = 0;
  logic  prev_req;
  logic  prev_ack;
  logic  req_low_seen;

  median_filter_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_req_i       (in_req),
    .in_pix_i       (in_pix),
    .in_ack_o       (in_ack),
    .median_o       (median),
    .median_valid_o (median_valid),
    .frame_done_o   (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ======================================================================
  // Checks and reference model.
  // ======================================================================

  task automatic compare_pixel(input median_pkg::pixel_t got, input median_pkg::pixel_t exp,
                               input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic compare_count(input int got, input int exp, input string what);
    if (got != exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // Plain sort of the nine neighbours, middle element is the median.
  function automatic median_pkg::pixel_t ref_median(input int r, input int c);
    int vals [9];
    int n;
    int tmp;
    n = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        vals[n] = frame_mem[r + dr][c + dc];
        n = n + 1;
      end
    end
    for (int i = 0; i < 9; i++) begin
      for (int j = 0; j < 8 - i; j++) begin
        if (vals[j] > vals[j + 1]) begin
          tmp         = vals[j];
          vals[j]     = vals[j + 1];
          vals[j + 1] = tmp;
        end
      end
    end
    return median_pkg::pixel_t'(vals[4]);
  endfunction

  task automatic fill_frame(input fill_t kind);
    median_pkg::pixel_t level;
    level = median_pkg::pixel_t'($urandom);
    for (int r = 0; r < `IMG_H; r++) begin
      for (int c = 0; c < `IMG_W; c++) begin
        case (kind)
          FILL_ZERO:    frame_mem[r][c] = '0;
          FILL_FULL:    frame_mem[r][c] = {`PIX_W{1'b1}};
          FILL_CONST:   frame_mem[r][c] = level;
          FILL_CHECKER: frame_mem[r][c] = ((r + c) % 2) ? {`PIX_W{1'b1}} : '0;
          default:      frame_mem[r][c] = median_pkg::pixel_t'($urandom);
        endcase
      end
    end
  endtask

  // A window is complete once its bottom-right pixel has been sent.
  task automatic queue_expected(input int npix);
    for (int r = 1; r < `IMG_H - 1; r++) begin
      for (int c = 1; c < `IMG_W - 1; c++) begin
        if ((r + 1) * `IMG_W + c + 1 < npix) begin
          exp_q.push_back(ref_median(r, c));
        end
      end
    end
  endtask

  // ======================================================================
  // Pixel source, four-phase handshake.
  // ======================================================================

  task automatic send_pixel(input median_pkg::pixel_t pix);
    int gap;
    gap = $urandom_range(3, 0);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    in_req = 1'b1;
    in_pix = pix;
    do begin
      @(posedge clk);
      #1;
    end while (in_ack !== 1'b1);
    in_req = 1'b0;
    do begin
      @(posedge clk);
      #1;
    end while (in_ack !== 1'b0);
  endtask

  task automatic run_frame(input fill_t kind, input int npix);
    fill_frame(kind);
    queue_expected(npix);
    for (int i = 0; i < npix; i++) begin
      send_pixel(frame_mem[i / `IMG_W][i % `IMG_W]);
    end
  endtask

  // ======================================================================
  // Output and handshake monitor, sampled on the falling edge.
  // ======================================================================

  always @(negedge clk) begin
    if (!rst_n) begin
      out_count    = 0;
      prev_req     = 1'b0;
      prev_ack     = 1'b0;
      req_low_seen = 1'b1;
    end else begin
      if (median_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          report_error("median output with no median expected");
        end else begin
          compare_pixel(median, exp_q.pop_front(), "median");
        end
        out_count++;
      end
      if (frame_done === 1'b1) begin
        compare_count(out_count, OUT_PER_FRAME, "medians per frame");
        out_count = 0;
        done_count++;
      end
      if (in_ack === 1'b1 && !prev_ack) begin
        if (!prev_req) report_error("ack rose without a request");
        if (!req_low_seen) report_error("second ack without request going low");
        req_low_seen = 1'b0;
      end
      if (in_ack === 1'b0 && prev_ack && prev_req) begin
        report_error("ack fell while request was still high");
      end
      if (!in_req) req_low_seen = 1'b1;
      prev_req = in_req;
      prev_ack = (in_ack === 1'b1);
    end
  end

  task automatic print_counts();
    $display("Checks done: %0d mismatches, %0d other errors, %0d frames done",
             mismatch_count, error_count, done_count);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, frames did not complete", cycle_count);
      print_counts();
      $display("Simulation failed");
      $finish;
    end
  end

  // ======================================================================
  // Test sequence.
  // ======================================================================

  initial begin
    void'($urandom(32'hfde1bd71));
    rst_n  = 1'b0;
    in_req = 1'b0;
    in_pix = '0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Random and corner frames sent back to back.
    for (int f = 0; f < 4; f++) begin
      run_frame(FILL_RANDOM, FRAME_PIX);
    end
    run_frame(FILL_ZERO, FRAME_PIX);
    run_frame(FILL_FULL, FRAME_PIX);
    run_frame(FILL_CONST, FRAME_PIX);
    run_frame(FILL_CHECKER, FRAME_PIX);

    // Partial frame cut short by a reset while medians are still in the pipeline.
    run_frame(FILL_RANDOM, 2 * `IMG_W + 9);
    rst_n = 1'b0;
    exp_q.delete();
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (10) begin
      if (in_ack !== 1'b0 || median_valid !== 1'b0 || frame_done !== 1'b0) begin
        report_error("outputs active after reset before any new pixel");
      end
      @(posedge clk);
      #1;
    end

    run_frame(FILL_RANDOM, FRAME_PIX);
    while (done_count < FULL_FRAMES) @(posedge clk);
    repeat (10) @(posedge clk);

    compare_count(done_count, FULL_FRAMES, "frame done pulses");
    if (exp_q.size() != 0) report_error("expected medians left over at the end");
    print_counts();
    if (mismatch_count == 0 && error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* source/median_filter_top.sv */
`timescale 1ns/10ps

module median_filter_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_req_i,
  input  median_pkg::pixel_t in_pix_i,
  output logic               in_ack_o,
  output median_pkg::pixel_t median_o,
  output logic               median_valid_o,
  output logic               frame_done_o
);

  logic                   push;
  logic                   pix_interior;
  logic                   pix_last;
  median_pkg::window_t    win;
  median_pkg::stage_tag_t win_tag;
  median_pkg::stage_tag_t out_tag;

  frame_ctrl u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_req_i     (in_req_i),
    .in_ack_o     (in_ack_o),
    .last_i       (pix_last),
    .pipe_last_i  (out_tag.last),
    .push_o       (push),
    .frame_done_o (frame_done_o)
  );

  pixel_counter u_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .step_i     (push),
    .pos_o      (),
    .interior_o (pix_interior),
    .last_o     (pix_last)
  );

  window_buffer u_window (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_i     (push),
    .pix_i      (in_pix_i),
    .interior_i (pix_interior),
    .last_i     (pix_last),
    .win_o      (win),
    .tag_o      (win_tag)
  );

  median_calc u_calc (
    .clk      (clk),
    .rst_n    (rst_n),
    .win_i    (win),
    .tag_i    (win_tag),
    .median_o (median_o),
    .tag_o    (out_tag)
  );

  assign median_valid_o = out_tag.valid;

endmodule

/* source/frame_ctrl.sv */
`timescale 1ns/10ps

module frame_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic in_req_i,
  output logic in_ack_o,
  input  logic last_i,
  input  logic pipe_last_i,
  output logic push_o,
  output logic frame_done_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_REQ_LOW,
    DRAIN
  } state_t;

  state_t state_q;
  logic   last_pend_q;
  logic   pipe_seen_q;
  logic   drain_done;

  // Accept the pixel in the cycle req is first seen.
  assign push_o = (state_q == IDLE) && in_req_i;

  // The last tag may come back before the source drops req.
  assign drain_done = pipe_last_i || pipe_seen_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      in_ack_o     <= 1'b0;
      last_pend_q  <= 1'b0;
      pipe_seen_q  <= 1'b0;
      frame_done_o <= 1'b0;
    end else begin
      frame_done_o <= 1'b0;
      if (pipe_last_i) pipe_seen_q <= 1'b1;
      case (state_q)
        IDLE: begin
          if (in_req_i) begin
            in_ack_o    <= 1'b1;
            last_pend_q <= last_i;
            state_q     <= WAIT_REQ_LOW;
          end
        end
        WAIT_REQ_LOW: begin
          if (!in_req_i) begin
            in_ack_o <= 1'b0;
            state_q  <= last_pend_q ? DRAIN : IDLE;
          end
        end
        DRAIN: begin
          if (drain_done) begin
            frame_done_o <= 1'b1;
            last_pend_q  <= 1'b0;
            pipe_seen_q  <= 1'b0;
            state_q      <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

/* source/pixel_counter.sv */
`timescale 1ns/10ps

`include "median_macros.svh"

module pixel_counter (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             step_i,
  output median_pkg::pos_t pos_o,
  output logic             interior_o,
  output logic             last_o
);

  localparam int ROW_W = $clog2(`IMG_H);
  localparam int COL_W = $clog2(`IMG_W);

  median_pkg::pos_t pos_q;
  logic             row_end;

  assign row_end = (pos_q.col == COL_W'(`IMG_W - 1));
  assign last_o  = row_end && (pos_q.row == ROW_W'(`IMG_H - 1));

  // Full window exists once two rows and two columns lie behind.
  assign interior_o = (pos_q.row >= ROW_W'(2)) && (pos_q.col >= COL_W'(2));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pos_q <= '0;
    end else if (step_i) begin
      if (last_o) begin
        pos_q <= '0;
      end else if (row_end) begin
        pos_q.col <= '0;
        pos_q.row <= pos_q.row + 1'b1;
      end else begin
        pos_q.col <= pos_q.col + 1'b1;
      end
    end
  end

  assign pos_o = pos_q;

endmodule

/* source/window_buffer.sv */
`timescale 1ns/10ps

`include "median_macros.svh"

module window_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   push_i,
  input  median_pkg::pixel_t     pix_i,
  input  logic                   interior_i,
  input  logic                   last_i,
  output median_pkg::window_t    win_o,
  output median_pkg::stage_tag_t tag_o
);

  localparam int PTR_W = $clog2(`IMG_W);

  function automatic median_pkg::row_t shift_row(median_pkg::row_t r, median_pkg::pixel_t p);
    median_pkg::row_t n;
    n.left  = r.mid;
    n.mid   = r.right;
    n.right = p;
    return n;
  endfunction

  // Row r-1 and row r-2 relative to the incoming pixel.
  median_pkg::pixel_t line1 [`IMG_W];
  median_pkg::pixel_t line2 [`IMG_W];

  logic [PTR_W-1:0]       wr_ptr;
  median_pkg::pixel_t     col_top;
  median_pkg::pixel_t     col_mid;
  median_pkg::window_t    win_q;
  median_pkg::stage_tag_t tag_q;

  assign col_top = line2[wr_ptr];
  assign col_mid = line1[wr_ptr];

  // ======================================================================
  // Column pointer.
  // ======================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (push_i) begin
      if (wr_ptr == PTR_W'(`IMG_W - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // ======================================================================
  // Line buffers and window.
  // ======================================================================

  always_ff @(posedge clk) begin
    if (push_i) begin
      line2[wr_ptr] <= line1[wr_ptr];
      line1[wr_ptr] <= pix_i;
      win_q.top     <= shift_row(win_q.top, col_top);
      win_q.mid     <= shift_row(win_q.mid, col_mid);
      win_q.bot     <= shift_row(win_q.bot, pix_i);
    end
  end

  // Single-cycle tag, one cycle behind the push.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tag_q <= '0;
    end else begin
      tag_q.valid <= push_i & interior_i;
      tag_q.last  <= push_i & last_i;
    end
  end

  assign win_o = win_q;
  assign tag_o = tag_q;

endmodule

/* source/median_calc.sv */
`timescale 1ns/10ps

module median_calc (
  input  logic                   clk,
  input  logic                   rst_n,
  input  median_pkg::window_t    win_i,
  input  median_pkg::stage_tag_t tag_i,
  output median_pkg::pixel_t     median_o,
  output median_pkg::stage_tag_t tag_o
);

  function automatic median_pkg::pixel_t max2(median_pkg::pixel_t a, median_pkg::pixel_t b);
    return (a > b) ? a : b;
  endfunction

  function automatic median_pkg::pixel_t min2(median_pkg::pixel_t a, median_pkg::pixel_t b);
    return (a > b) ? b : a;
  endfunction

  // ======================================================================
  // Tag pipeline, four deep to match the data path.
  // ======================================================================

  median_pkg::stage_tag_t s1_tag, s2_tag, s3_tag, s4_tag;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_tag <= '0;
      s2_tag <= '0;
      s3_tag <= '0;
      s4_tag <= '0;
    end else begin
      s1_tag <= tag_i;
      s2_tag <= s1_tag;
      s3_tag <= s2_tag;
      s4_tag <= s3_tag;
    end
  end

  // ======================================================================
  // Data pipeline.
  // ======================================================================

  median_pkg::window_t s1_win;
  median_pkg::triple_t top_sort, mid_sort, bot_sort;
  median_pkg::triple_t s2_top, s2_mid, s2_bot;
  median_pkg::triple_t med_sort;
  median_pkg::triple_t s3_q;
  median_pkg::triple_t final_sort;
  median_pkg::pixel_t  s4_median;

  // Stage 1 captures the window.
  always_ff @(posedge clk) begin
    s1_win <= win_i;
  end

  sort3 u_sort_top (
    .a_i      (s1_win.top.left),
    .b_i      (s1_win.top.mid),
    .c_i      (s1_win.top.right),
    .sorted_o (top_sort)
  );

  sort3 u_sort_mid (
    .a_i      (s1_win.mid.left),
    .b_i      (s1_win.mid.mid),
    .c_i      (s1_win.mid.right),
    .sorted_o (mid_sort)
  );

  sort3 u_sort_bot (
    .a_i      (s1_win.bot.left),
    .b_i      (s1_win.bot.mid),
    .c_i      (s1_win.bot.right),
    .sorted_o (bot_sort)
  );

  // Stage 2 holds the sorted rows.
  always_ff @(posedge clk) begin
    s2_top <= top_sort;
    s2_mid <= mid_sort;
    s2_bot <= bot_sort;
  end

  sort3 u_sort_med (
    .a_i      (s2_top.med),
    .b_i      (s2_mid.med),
    .c_i      (s2_bot.med),
    .sorted_o (med_sort)
  );

  // Stage 3 narrows to three candidates, low bound in min, high bound in max.
  always_ff @(posedge clk) begin
    s3_q.min <= max2(max2(s2_top.min, s2_mid.min), s2_bot.min);
    s3_q.med <= med_sort.med;
    s3_q.max <= min2(min2(s2_top.max, s2_mid.max), s2_bot.max);
  end

  sort3 u_sort_final (
    .a_i      (s3_q.min),
    .b_i      (s3_q.med),
    .c_i      (s3_q.max),
    .sorted_o (final_sort)
  );

  always_ff @(posedge clk) begin
    s4_median <= final_sort.med;
  end

  assign median_o = s4_median;
  assign tag_o    = s4_tag;

endmodule

/* source/sort3.sv */
`timescale 1ns/10ps

module sort3 (
  input  median_pkg::pixel_t  a_i,
  input  median_pkg::pixel_t  b_i,
  input  median_pkg::pixel_t  c_i,
  output median_pkg::triple_t sorted_o
);

  median_pkg::pixel_t hi_ab;
  median_pkg::pixel_t lo_ab;
  median_pkg::pixel_t lo_abc;

  // First exchange orders a and b.
  assign hi_ab = (a_i > b_i) ? a_i : b_i;
  assign lo_ab = (a_i > b_i) ? b_i : a_i;

  // Second exchange finds the overall max.
  assign sorted_o.max = (hi_ab > c_i) ? hi_ab : c_i;
  assign lo_abc       = (hi_ab > c_i) ? c_i : hi_ab;

  // Third exchange splits the two remaining values.
  assign sorted_o.med = (lo_ab > lo_abc) ? lo_ab : lo_abc;
  assign sorted_o.min = (lo_ab > lo_abc) ? lo_abc : lo_ab;

endmodule

/* source/median_pkg.sv */
`include "median_macros.svh"

package median_pkg;

  typedef logic [`PIX_W-1:0] pixel_t;

  // Three horizontally adjacent pixels.
  typedef struct packed {
    pixel_t left;
    pixel_t mid;
    pixel_t right;
  } row_t;

  // Full 3x3 neighbourhood, top row first.
  typedef struct packed {
    row_t top;
    row_t mid;
    row_t bot;
  } window_t;

  // Result of a three-way sort.
  typedef struct packed {
    pixel_t max;
    pixel_t med;
    pixel_t min;
  } triple_t;

  typedef struct packed {
    logic [$clog2(`IMG_H)-1:0] row;
    logic [$clog2(`IMG_W)-1:0] col;
  } pos_t;

  // Travels next to the data through the window and the sorter.
  typedef struct packed {
    logic valid;
    logic last;
  } stage_tag_t;

endpackage

/* source/median_macros.svh */
`ifndef MEDIAN_MACROS_SVH
`define MEDIAN_MACROS_SVH

// ======================================================================
// Pixel format.
// ======================================================================

`define PIX_W 8

// ======================================================================
// Frame geometry.
// ======================================================================

// Pixels per row.
`define IMG_W 16

// Rows per frame.
`define IMG_H 8

`endif
